/* flist.f */
rtl/busPkg.sv
rtl/sampleDspPkg.sv
rtl/regDecode.sv
rtl/topRegs.sv
rtl/adcReclock.sv
rtl/dacChannel.sv
rtl/videoSwitchRegs.sv
rtl/demodBoardTop.sv
verif/tbClockGen.sv
verif/demodBoardTb.sv

/* Makefile */
TOP = demodBoardTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* verif/demodBoardTb.sv */
`timescale 1ns/1ps

module demodBoardTb;

    import busPkg::*;
    import sampleDspPkg::*;

    localparam int          numDacs       = 3;
    localparam logic [15:0] versionNumber = 16'd627;

    // Step operations
    localparam logic [1:0] opWrite    = 2'd0;
    localparam logic [1:0] opRead     = 2'd1;
    localparam logic [1:0] opAdcRun   = 2'd2;
    localparam logic [1:0] opPinCheck = 2'd3;

    // Pin numbers for output checks, DAC k is pin k
    localparam int pinVideo0In  = 8;
    localparam int pinVideo0Out = 9;
    localparam int pinVideo1In  = 10;
    localparam int pinVideo1Out = 11;

    localparam byteEnT rdHigh   = 4'b0001;   // Read steps carry rd in strobe bit 0
    localparam byteEnT rdLow    = 4'b0000;
    localparam byteEnT allLanes = 4'b1111;

    typedef struct packed {
        logic [1:0] op;
        addrT       addr;       // Register address or pin number
        dataT       data;       // Write data, ADC word count or edges to wait
        byteEnT     strobes;
        dataT       expected;
    } stepT;

    logic                 clk;
    logic                 arstN;
    logic                 cs;
    logic                 rd;
    byteEnT               wr;
    addrT                 addr;
    dataT                 dataIn;
    dataT                 dataOut;
    adcCodeT              adc;
    dacCodeT [numDacs-1:0] dacData;
    vidSelT               video0InSelect;
    vidSelT               video0OutSelect;
    vidSelT               video1InSelect;
    vidSelT               video1OutSelect;

    stepT        stepTable[$];
    string       stepNames[$];
    logic [31:0] rngState   = 32'hba34_2109;
    int          errors     = 0;
    int          checks     = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    tbClockGen u_tbClockGen (.clk(clk), .arstN(arstN));

    demodBoardTop #(.numDacs(numDacs), .versionNumber(versionNumber)) u_demodBoardTop (
        .clk(clk), .arstN(arstN),
        .cs(cs), .rd(rd), .wr(wr), .addr(addr), .dataIn(dataIn), .dataOut(dataOut),
        .adc(adc), .dacData(dacData),
        .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
        .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect)
    );

    // **************************************************
    // Helpers
    // **************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic addrT regAddr(input regionT region, input offsetT offset);
        return {region, offset};
    endfunction

    function automatic addrT testAddr(input int k);
        return regAddr(topRegion, offsetT'(offTestBase + k));
    endfunction

    // Offset binary DAC word is the signed value scaled to 14 bits plus half scale
    function automatic dataT dacCodeFor(input logic signed [17:0] s);
        logic [13:0] code;
        code = 14'(s >>> 4) + 14'h2000;
        return {18'b0, code};
    endfunction

    function automatic dataT pinValue(input int pin);
        case (pin)
            pinVideo0In:  return {30'b0, video0InSelect};
            pinVideo0Out: return {30'b0, video0OutSelect};
            pinVideo1In:  return {30'b0, video1InSelect};
            pinVideo1Out: return {30'b0, video1OutSelect};
            default:      return {18'b0, dacData[pin]};
        endcase
    endfunction

    task automatic addStep(input string name, input logic [1:0] op, input addrT a,
                           input dataT d, input byteEnT s, input dataT e);
        stepT step;
        step.op       = op;
        step.addr     = a;
        step.data     = d;
        step.strobes  = s;
        step.expected = e;
        stepTable.push_back(step);
        stepNames.push_back(name);
    endtask

    task automatic checkValue(input string name, input dataT expected, input dataT actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // **************************************************
    // Bus and pin operations
    // **************************************************

    task automatic busWrite(input addrT a, input dataT d, input byteEnT s);
        @(posedge clk);
        #1;
        cs     = 1'b1;
        wr     = s;
        addr   = a;
        dataIn = d;
        @(posedge clk);         // Write edge
        #1;
        cs = 1'b0;
        wr = '0;
    endtask

    task automatic busRead(input string name, input addrT a, input logic rdLevel,
                           input dataT expected);
        @(posedge clk);
        #1;
        cs   = 1'b1;
        rd   = rdLevel;
        addr = a;
        @(negedge clk);
        checkValue(name, expected, dataOut);
        @(posedge clk);
        #1;
        cs = 1'b0;
        rd = 1'b0;
    endtask

    task automatic checkPin(input string name, input int pin, input int edges,
                            input dataT expected);
        repeat (edges) @(posedge clk);
        @(negedge clk);
        checkValue(name, expected, pinValue(pin));
    endtask

    // Each ADC word shows up on every DAC four edges after it is driven
    task automatic runAdc(input string name, input int count);
        adcCodeT history[$];
        adcCodeT word;
        for (int i = 0; i < count + 4; i++) begin
            @(posedge clk);
            #1;
            rngState = xorshift32(rngState);
            word     = rngState[13:0];
            adc      = word;
            history.push_back(word);
            @(negedge clk);
            if (i >= 4) begin
                for (int k = 0; k < numDacs; k++) begin
                    checkValue($sformatf("%s w%0d dac%0d", name, i - 4, k),
                               dataT'(history[i - 4]), dataT'(dacData[k]));
                end
            end
        end
        @(posedge clk);
        #1;
        adc = adcMidscale;
    endtask

    // **************************************************
    // Stimulus table
    // **************************************************

    task automatic buildTable();
        addrT verAddr;
        addrT srcAddr;
        addrT vidAddr;
        verAddr = regAddr(topRegion, offVersion);
        srcAddr = regAddr(topRegion, offDacSource);
        vidAddr = regAddr(videoRegion, offVideo);
        for (int k = 0; k < numDacs; k++) begin
            addStep($sformatf("reset dac%0d", k), opPinCheck, addrT'(k), 0, 0, 32'h2000);
            addStep($sformatf("reset test%0d", k), opRead, testAddr(k), 0, rdHigh, 0);
        end
        addStep("reset source", opRead, srcAddr, 0, rdHigh, 0);
        addStep("reset video0 in", opPinCheck, addrT'(pinVideo0In), 0, 0, 0);
        addStep("reset video0 out", opPinCheck, addrT'(pinVideo0Out), 0, 0, 0);
        addStep("reset video1 in", opPinCheck, addrT'(pinVideo1In), 0, 0, 0);
        addStep("reset video1 out", opPinCheck, addrT'(pinVideo1Out), 0, 0, 0);
        // Version is read-only
        addStep("version read", opRead, verAddr, 0, rdHigh, dataT'(versionNumber));
        addStep("version write", opWrite, verAddr, 32'hffff_ffff, allLanes, 0);
        addStep("version after write", opRead, verAddr, 0, rdHigh, dataT'(versionNumber));
        addStep("adc to dacs", opAdcRun, 0, 40, 0, 0);
        // Test sources, lanes 0 to 2 select srcTest
        addStep("source test", opWrite, srcAddr, 32'h0001_0101, 4'b0111, 0);
        addStep("source readback", opRead, srcAddr, 0, rdHigh, 32'h0001_0101);
        addStep("test0 lane0", opWrite, testAddr(0), 32'h0003_a5c3, 4'b0001, 0);
        addStep("test0 lane0 not yet", opPinCheck, 0, 1, 0, 32'h2000);
        addStep("test0 lane0 dac", opPinCheck, 0, 1, 0, dacCodeFor(18'h000c3));
        addStep("test0 lane0 readback", opRead, testAddr(0), 0, rdHigh, 32'h0000_00c3);
        addStep("test0 all lanes", opWrite, testAddr(0), 32'hfff2_a5c3, allLanes, 0);
        addStep("test0 all dac", opPinCheck, 0, 2, 0, dacCodeFor(18'h2a5c3));
        addStep("test0 all readback", opRead, testAddr(0), 0, rdHigh, 32'h0002_a5c3);
        addStep("test2 write", opWrite, testAddr(2), 32'h0001_2345, 4'b0111, 0);
        addStep("test2 dac", opPinCheck, 2, 2, 0, dacCodeFor(18'h12345));
        addStep("test2 readback", opRead, testAddr(2), 0, rdHigh, 32'h0001_2345);
        addStep("test1 write", opWrite, testAddr(1), 32'h0000_1000, allLanes, 0);
        addStep("test1 dac", opPinCheck, 1, 2, 0, dacCodeFor(18'h01000));
        addStep("source1 code 7", opWrite, srcAddr, 32'h0000_0700, 4'b0010, 0);
        addStep("source1 code 7 dac", opPinCheck, 1, 2, 0, 32'h2000);
        addStep("source code 7 readback", opRead, srcAddr, 0, rdHigh, 32'h0001_0701);
        // Video switch, out-selects swap 1 and 2
        addStep("video 1 2", opWrite, vidAddr, 32'h0000_0201, 4'b0011, 0);
        addStep("video0 in 1", opPinCheck, addrT'(pinVideo0In), 0, 0, 1);
        addStep("video0 out 1", opPinCheck, addrT'(pinVideo0Out), 0, 0, 2);
        addStep("video1 in 2", opPinCheck, addrT'(pinVideo1In), 0, 0, 2);
        addStep("video1 out 2", opPinCheck, addrT'(pinVideo1Out), 0, 0, 1);
        addStep("video 1 2 readback", opRead, vidAddr, 0, rdHigh, 32'h0000_0201);
        addStep("video 0 3", opWrite, vidAddr, 32'h0000_0300, 4'b0011, 0);
        addStep("video0 in 0", opPinCheck, addrT'(pinVideo0In), 0, 0, 0);
        addStep("video0 out 0", opPinCheck, addrT'(pinVideo0Out), 0, 0, 0);
        addStep("video1 in 3", opPinCheck, addrT'(pinVideo1In), 0, 0, 3);
        addStep("video1 out 3", opPinCheck, addrT'(pinVideo1Out), 0, 0, 3);
        addStep("video 0 3 readback", opRead, vidAddr, 0, rdHigh, 32'h0000_0300);
        // Unmapped regions and rd low
        addStep("unmapped region 5", opRead, regAddr(5'd5, 8'd0), 0, rdHigh, 0);
        addStep("unmapped region 31", opRead, regAddr(5'd31, 8'd3), 0, rdHigh, 0);
        addStep("version rd low", opRead, verAddr, 0, rdLow, 0);
        addStep("video rd low", opRead, vidAddr, 0, rdLow, 0);
    endtask

    // **************************************************
    // Run
    // **************************************************

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run went past %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        stepT step;
        cs     = 1'b0;
        rd     = 1'b0;
        wr     = '0;
        addr   = '0;
        dataIn = '0;
        adc    = adcMidscale;
        buildTable();
        cycleLimit = 10 * stepTable.size() + 20;
        foreach (stepTable[i]) begin
            if (stepTable[i].op == opAdcRun) begin
                cycleLimit += int'(stepTable[i].data);   // Long ADC runs
            end
        end
        @(posedge arstN);
        foreach (stepTable[i]) begin
            step = stepTable[i];
            case (step.op)
                opWrite:    busWrite(step.addr, step.data, step.strobes);
                opRead:     busRead(stepNames[i], step.addr, step.strobes[0], step.expected);
                opAdcRun:   runAdc(stepNames[i], int'(step.data));
                opPinCheck: checkPin(stepNames[i], int'(step.addr), int'(step.data),
                                     step.expected);
            endcase
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
    output logic clk,
    output logic arstN
);

    localparam int resetCycles = 3;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    // Reset held over the first rising edges
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
    end

endmodule

/* rtl/demodBoardTop.sv */
`timescale 1ns/1ps

module demodBoardTop #(
    parameter int          numDacs       = 3,
    parameter logic [15:0] versionNumber = 16'd627
) (
    input  logic                                clk,
    input  logic                                arstN,
    // Register bus
    input  logic                                cs,
    input  logic                                rd,
    input  busPkg::byteEnT                      wr,
    input  busPkg::addrT                        addr,
    input  busPkg::dataT                        dataIn,
    output busPkg::dataT                        dataOut,
    // Converters
    input  sampleDspPkg::adcCodeT               adc,
    output sampleDspPkg::dacCodeT [numDacs-1:0] dacData,
    // Video switch
    output sampleDspPkg::vidSelT                video0InSelect,
    output sampleDspPkg::vidSelT                video0OutSelect,
    output sampleDspPkg::vidSelT                video1InSelect,
    output sampleDspPkg::vidSelT                video1OutSelect
);

    import busPkg::*;
    import sampleDspPkg::*;

    logic                 topSel;
    logic                 videoSel;
    dataT                 topDout;
    dataT                 videoDout;
    sampleT               adcSample;
    dacSrcT [numDacs-1:0] dacSource;
    sampleT [numDacs-1:0] testValue;

    // **************************************************
    // Register bus
    // **************************************************

    regDecode u_regDecode (
        .cs(cs), .rd(rd), .addr(addr),
        .topDout(topDout), .videoDout(videoDout),
        .topSel(topSel), .videoSel(videoSel),
        .dataOut(dataOut)
    );

    topRegs #(.numDacs(numDacs), .versionNumber(versionNumber)) u_topRegs (
        .clk(clk), .arstN(arstN),
        .sel(topSel), .wr(wr), .addr(addr), .dataIn(dataIn), .dataOut(topDout),
        .dacSource(dacSource),
        .testValue(testValue)
    );

    videoSwitchRegs u_videoSwitchRegs (
        .clk(clk), .arstN(arstN),
        .sel(videoSel), .wr(wr), .addr(addr), .dataIn(dataIn), .dataOut(videoDout),
        .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
        .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect)
    );

    // **************************************************
    // Sample path, ADC to DACs
    // **************************************************

    adcReclock u_adcReclock (
        .clk(clk), .arstN(arstN), .adc(adc), .sample(adcSample)
    );

    for (genvar k = 0; k < numDacs; k++) begin : g_dac
        dacChannel u_dacChannel (
            .clk(clk), .arstN(arstN),
            .source(dacSource[k]), .adcSample(adcSample), .testValue(testValue[k]),
            .dacCode(dacData[k])
        );
    end

endmodule

/* rtl/videoSwitchRegs.sv */
`timescale 1ns/1ps

module videoSwitchRegs (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 sel,
    input  busPkg::byteEnT       wr,
    input  busPkg::addrT         addr,
    input  busPkg::dataT         dataIn,
    output busPkg::dataT         dataOut,
    output sampleDspPkg::vidSelT video0InSelect,
    output sampleDspPkg::vidSelT video0OutSelect,
    output sampleDspPkg::vidSelT video1InSelect,
    output sampleDspPkg::vidSelT video1OutSelect
);

    import busPkg::*;
    import sampleDspPkg::*;

    logic videoHit;

    // Output switch has inputs 1 and 2 swapped on the board
    function automatic vidSelT boardRemap(input vidSelT s);
        case (s)
            2'b01:   return 2'b10;
            2'b10:   return 2'b01;
            default: return s;
        endcase
    endfunction

    assign videoHit = sel && (offsetOf(addr) == offVideo);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            video0InSelect <= '0;
            video1InSelect <= '0;
        end else if (videoHit) begin
            if (wr[0]) begin
                video0InSelect <= dataIn[1:0];
            end
            if (wr[1]) begin
                video1InSelect <= dataIn[9:8];
            end
        end
    end

    assign video0OutSelect = boardRemap(video0InSelect);
    assign video1OutSelect = boardRemap(video1InSelect);

    assign dataOut = (offsetOf(addr) == offVideo) ?
                     {16'h0000, 6'b0, video1InSelect, 6'b0, video0InSelect} : '0;

endmodule

/* rtl/dacChannel.sv */
`timescale 1ns/1ps

module dacChannel (
    input  logic                  clk,
    input  logic                  arstN,
    input  sampleDspPkg::dacSrcT  source,
    input  sampleDspPkg::sampleT  adcSample,
    input  sampleDspPkg::sampleT  testValue,
    output sampleDspPkg::dacCodeT dacCode
);

    import sampleDspPkg::*;

    sampleT selSample;

    // **************************************************
    // Source mux
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            selSample <= '0;
        end else begin
            case (source)
                srcAdc: begin
                    selSample <= adcSample;
                end
                srcTest: begin
                    selSample <= testValue;
                end
                default: begin
                    selSample <= '0;        // Old loop diagnostics slot
                end
            endcase
        end
    end

    // **************************************************
    // Back to offset binary, top 14 bits
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dacCode <= dacMidscale;
        end else begin
            dacCode <= {~selSample[17], selSample[16:4]};
        end
    end

    // Pins must never see X once out of reset
    dacCodeKnown: assert property (
        @(posedge clk) disable iff (!arstN) !$isunknown(dacCode)
    ) else $error("dacChannel: unknown DAC code");

endmodule

/* rtl/adcReclock.sv */
`timescale 1ns/1ps

module adcReclock (
    input  logic                  clk,
    input  logic                  arstN,
    input  sampleDspPkg::adcCodeT adc,
    output sampleDspPkg::sampleT  sample
);

    import sampleDspPkg::*;

    adcCodeT adcReg;

    // Pin capture
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            adcReg <= adcMidscale;
        end else begin
            adcReg <= adc;
        end
    end

    // Offset binary to signed 18 bit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sample <= '0;
        end else begin
            sample <= adcToSample(adcReg);
        end
    end

endmodule

/* rtl/topRegs.sv */
`timescale 1ns/1ps

module topRegs #(
    parameter int          numDacs       = 3,
    parameter logic [15:0] versionNumber = 16'd627
) (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               sel,
    input  busPkg::byteEnT                     wr,
    input  busPkg::addrT                       addr,
    input  busPkg::dataT                       dataIn,
    output busPkg::dataT                       dataOut,
    output sampleDspPkg::dacSrcT [numDacs-1:0] dacSource,
    output sampleDspPkg::sampleT [numDacs-1:0] testValue
);

    import busPkg::*;
    import sampleDspPkg::*;

    localparam dataT versionWord = {16'h0000, versionNumber};

    offsetT offset;

    assign offset = offsetOf(addr);

    // **************************************************
    // Register writes
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dacSource <= '0;
            testValue <= '0;
        end else if (sel) begin
            for (int k = 0; k < numDacs; k++) begin
                // One nibble per byte lane, lane k for DAC k
                if (offset == offDacSource && wr[k]) begin
                    dacSource[k] <= dataIn[8*k +: 4];
                end
                if (offset == offsetT'(offTestBase + k)) begin
                    if (wr[0]) begin
                        testValue[k][7:0] <= dataIn[7:0];
                    end
                    if (wr[1]) begin
                        testValue[k][15:8] <= dataIn[15:8];
                    end
                    if (wr[2]) begin
                        testValue[k][17:16] <= dataIn[17:16];   // Only 2 bits live in lane 2
                    end
                end
            end
        end
    end

    // **************************************************
    // Readback
    // **************************************************

    always_comb begin
        dataOut = '0;
        if (offset == offVersion) begin
            dataOut = versionWord;
        end
        for (int k = 0; k < numDacs; k++) begin
            if (offset == offDacSource) begin
                dataOut[8*k +: 4] = dacSource[k];
            end
            if (offset == offsetT'(offTestBase + k)) begin
                dataOut = {14'h0000, testValue[k]};   // Zero extended
            end
        end
    end

    // A version write must not fall through onto any other register
    versionReadOnly: assert property (
        @(posedge clk) disable iff (!arstN)
        (sel && (|wr) && offset == offVersion) |=> ($stable(dacSource) && $stable(testValue))
    ) else $error("topRegs: write to version register changed a register");

endmodule

/* rtl/regDecode.sv */
`timescale 1ns/1ps

module regDecode (
    input  logic         cs,
    input  logic         rd,
    input  busPkg::addrT addr,
    input  busPkg::dataT topDout,
    input  busPkg::dataT videoDout,
    output logic         topSel,
    output logic         videoSel,
    output busPkg::dataT dataOut
);

    import busPkg::*;

    regionT region;

    // **************************************************
    // Block selects
    // **************************************************

    assign region = regionOf(addr);

    assign topSel   = cs && (region == topRegion);
    assign videoSel = cs && (region == videoRegion);

    // **************************************************
    // Read data mux
    // **************************************************

    always_comb begin
        dataOut = '0;
        if (cs && rd) begin
            case (region)
                topRegion: begin
                    dataOut = topDout;
                end
                videoRegion: begin
                    dataOut = videoDout;
                end
                default: begin
                    dataOut = '0;       // Unmapped region
                end
            endcase
        end
    end

    // Only one register block may own a bus cycle
    always_comb begin
        assert (!(topSel && videoSel))
            else $error("regDecode: top and video blocks selected together");
    end

endmodule

/* rtl/sampleDspPkg.sv */
package sampleDspPkg;

    // Converter and sample formats
    typedef logic [13:0]        adcCodeT;   // Offset binary from the ADC pins
    typedef logic signed [17:0] sampleT;    // Internal two's complement sample
    typedef logic [13:0]        dacCodeT;   // Offset binary to the DAC pins

    // DAC source select
    typedef logic [3:0] dacSrcT;

    localparam dacSrcT srcAdc  = 4'd0;
    localparam dacSrcT srcTest = 4'd1;
    // Any other code gives a zero sample

    // Zero signal in offset binary
    localparam adcCodeT adcMidscale = 14'h2000;
    localparam dacCodeT dacMidscale = 14'h2000;

    // Video switch select
    typedef logic [1:0] vidSelT;

    // Offset binary to signed, MSB inverted and scaled up to 18 bits
    function automatic sampleT adcToSample(input adcCodeT code);
        return {~code[13], code[12:0], 4'b0000};
    endfunction

endpackage

/* rtl/busPkg.sv */
package busPkg;

    // Register bus widths
    typedef logic [12:0] addrT;     // Word address
    typedef logic [31:0] dataT;
    typedef logic [3:0]  byteEnT;   // One write strobe per byte lane
    typedef logic [4:0]  regionT;   // Upper address bits 12:8
    typedef logic [7:0]  offsetT;   // Register offset inside a region

    // Region codes
    localparam regionT topRegion   = 5'd0;
    localparam regionT videoRegion = 5'd1;

    // Top register offsets
    localparam offsetT offVersion   = 8'd0;
    localparam offsetT offDacSource = 8'd1;
    localparam offsetT offTestBase  = 8'd2;   // Test value k at offTestBase + k

    localparam offsetT offVideo = 8'd0;       // Video switch register

    function automatic regionT regionOf(input addrT a);
        return a[12:8];
    endfunction

    function automatic offsetT offsetOf(input addrT a);
        return a[7:0];
    endfunction

endpackage
